/* source/stream_pkg.sv */
package stream_pkg;

    // Receiver sample width and the sample type carried end to end
    localparam int SAMPLE_W = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // Two samples share one FIFO word so the crossing runs at half rate
    typedef struct packed {
        sample_t first;
        sample_t second;
        logic    has_second;
        logic    last;
    } pair_t;

    localparam int FIFO_DEPTH = 8;
    localparam int DROP_CNT_W = 16;

    // Pointers carry one wrap bit above the address bits
    localparam int PTR_W = $clog2(FIFO_DEPTH) + 1;

    typedef logic [PTR_W-1:0] ptr_t;

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        // Each binary bit is the XOR of all Gray bits at and above it
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* source/stream_if.sv */
`timescale 1ns/1ps

// Streaming link with valid/ready handshake and a frame-end marker
interface stream_if #(
    parameter type payload_t = logic
);

    payload_t data;
    logic     last;
    logic     valid;
    logic     ready;

    modport source (
        output data,
        output last,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

/* source/gray_sync.sv */
`timescale 1ns/1ps

module gray_sync (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  stream_pkg::ptr_t gray_i,
    output stream_pkg::ptr_t gray_o
);

    import stream_pkg::*;

    ptr_t meta_q;
    ptr_t sync_q;

    // Only one bit moves per pointer step, so a late capture still
    // resolves to either the old or the new pointer value
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= gray_i;
            sync_q <= meta_q;
        end
    end

    assign gray_o = sync_q;

endmodule

/* source/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
    parameter int  DEPTH     = stream_pkg::FIFO_DEPTH,
    parameter type payload_t = stream_pkg::pair_t
) (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  logic     out_clk_i,
    stream_if.sink   wr,
    stream_if.source rd
);

    import stream_pkg::*;

    localparam int AW = $clog2(DEPTH);

    typedef struct packed {
        logic     last;
        payload_t data;
    } entry_t;

    entry_t mem [DEPTH];

    // Write domain state
    ptr_t   wr_ptr;
    ptr_t   wr_gray;
    ptr_t   rd_gray_sync;
    ptr_t   rd_bin_sync;
    logic   full;
    logic   wr_en;
    entry_t wr_entry;

    // Read domain state
    ptr_t   fetch_ptr;
    ptr_t   fetch_nxt;
    ptr_t   freed_nxt;
    ptr_t   rd_gray;
    ptr_t   wr_gray_sync;
    ptr_t   wr_bin_sync;
    logic   not_empty;
    logic   rd_load;
    logic   out_valid_q;
    logic   valid_nxt;
    entry_t out_q;

    // The read side publishes the freed pointer, the write side its own pointer
    gray_sync rd_ptr_sync_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .gray_i   (rd_gray),
        .gray_o   (rd_gray_sync)
    );

    gray_sync wr_ptr_sync_inst (
        .clk_i    (out_clk_i),
        .reset_ni (reset_ni),
        .gray_i   (wr_gray),
        .gray_o   (wr_gray_sync)
    );

    // Full when the address bits match and the wrap bits differ
    assign rd_bin_sync = gray2bin(rd_gray_sync);
    assign full = (wr_ptr[AW-1:0] == rd_bin_sync[AW-1:0]) && (wr_ptr[AW] != rd_bin_sync[AW]);
    assign wr.ready = !full;
    assign wr_en = wr.valid && !full;

    assign wr_entry.last = wr.last;
    assign wr_entry.data = wr.data;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr  <= '0;
            wr_gray <= '0;
        end else if (wr_en) begin
            wr_ptr  <= wr_ptr + 1'b1;
            wr_gray <= bin2gray(wr_ptr + 1'b1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_entry;
        end
    end

    assign wr_bin_sync = gray2bin(wr_gray_sync);
    assign not_empty = (wr_bin_sync != fetch_ptr);

    // Reload the output word when it is empty or leaving this cycle
    assign rd_load = not_empty && (!out_valid_q || rd.ready);
    assign fetch_nxt = fetch_ptr + ptr_t'(rd_load);

    always_comb begin
        if (rd_load) begin
            valid_nxt = 1'b1;
        end else if (rd.ready) begin
            valid_nxt = 1'b0;
        end else begin
            valid_nxt = out_valid_q;
        end
    end

    // A slot is only freed once its word has left the output register,
    // which keeps the total capacity at DEPTH words
    assign freed_nxt = fetch_nxt - ptr_t'(valid_nxt);

    always_ff @(posedge out_clk_i) begin
        if (!reset_ni) begin
            fetch_ptr   <= '0;
            out_valid_q <= 1'b0;
            rd_gray     <= '0;
        end else begin
            fetch_ptr   <= fetch_nxt;
            out_valid_q <= valid_nxt;
            rd_gray     <= bin2gray(freed_nxt);
        end
    end

    always_ff @(posedge out_clk_i) begin
        if (rd_load) begin
            out_q <= mem[fetch_ptr[AW-1:0]];
        end
    end

    assign rd.data  = out_q.data;
    assign rd.last  = out_q.last;
    assign rd.valid = out_valid_q;

endmodule

/* source/pair_packer.sv */
`timescale 1ns/1ps

module pair_packer (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  stream_pkg::sample_t               sample_i,
    input  logic                              sample_valid_i,
    input  logic                              sample_last_i,
    stream_if.source                          out,
    output logic [stream_pkg::DROP_CNT_W-1:0] drop_count_o
);

    import stream_pkg::*;

    sample_t                 first_q;
    logic                    half_q;
    pair_t                   pair_q;
    logic                    pair_valid_q;
    logic [DROP_CNT_W-1:0]   drop_cnt_q;
    logic [DROP_CNT_W:0]     drop_sum;

    // Holding the first half of a pair between samples
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            half_q       <= 1'b0;
            pair_valid_q <= 1'b0;
        end else begin
            pair_valid_q <= 1'b0;
            if (sample_valid_i) begin
                if (half_q) begin
                    half_q       <= 1'b0;
                    pair_valid_q <= 1'b1;
                end else if (sample_last_i) begin
                    // Frame ended on the first half so the pair closes alone
                    pair_valid_q <= 1'b1;
                end else begin
                    half_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            if (half_q) begin
                pair_q.first      <= first_q;
                pair_q.second     <= sample_i;
                pair_q.has_second <= 1'b1;
                pair_q.last       <= sample_last_i;
            end else begin
                first_q           <= sample_i;
                pair_q.first      <= sample_i;
                pair_q.second     <= '0;
                pair_q.has_second <= 1'b0;
                pair_q.last       <= sample_last_i;
            end
        end
    end

    // The input cannot stall, so a pair refused by the FIFO is lost here
    assign drop_sum = {1'b0, drop_cnt_q} + (pair_q.has_second ? 2 : 1);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            drop_cnt_q <= '0;
        end else if (pair_valid_q && !out.ready) begin
            drop_cnt_q <= drop_sum[DROP_CNT_W] ? '1 : drop_sum[DROP_CNT_W-1:0];
        end
    end

    assign out.data     = pair_q;
    assign out.last     = pair_q.last;
    assign out.valid    = pair_valid_q;
    assign drop_count_o = drop_cnt_q;

endmodule

/* source/pair_unpacker.sv */
`timescale 1ns/1ps

module pair_unpacker (
    input  logic                out_clk_i,
    input  logic                reset_ni,
    stream_if.sink              in,
    output stream_pkg::sample_t sample_o,
    output logic                sample_valid_o,
    output logic                sample_last_o,
    input  logic                sample_ready_i
);

    import stream_pkg::*;

    pair_t pair_q;
    logic  last_q;
    logic  full_q;
    logic  half_q;
    logic  final_half;
    logic  take;

    // The second half is the final one unless the pair holds a single sample
    assign final_half = half_q || !pair_q.has_second;

    // A new pair is accepted while empty or while the last sample leaves
    assign in.ready = !full_q || (sample_ready_i && final_half);
    assign take     = in.valid && in.ready;

    always_ff @(posedge out_clk_i) begin
        if (!reset_ni) begin
            full_q <= 1'b0;
            half_q <= 1'b0;
        end else if (take) begin
            full_q <= 1'b1;
            half_q <= 1'b0;
        end else if (full_q && sample_ready_i) begin
            if (final_half) begin
                full_q <= 1'b0;
                half_q <= 1'b0;
            end else begin
                half_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge out_clk_i) begin
        if (take) begin
            pair_q <= in.data;
            last_q <= in.last;
        end
    end

    assign sample_o       = half_q ? pair_q.second : pair_q.first;
    assign sample_valid_o = full_q;

    // Frame end is flagged only on the pair's final sample
    assign sample_last_o = full_q && final_half && last_q;

endmodule

/* source/sample_cdc_top.sv */
`timescale 1ns/1ps

module sample_cdc_top (
    input  logic                              clk_i,
    input  logic                              out_clk_i,
    input  logic                              reset_ni,

    // Sampling domain input, which has no back-pressure
    input  stream_pkg::sample_t               sample_i,
    input  logic                              sample_valid_i,
    input  logic                              sample_last_i,

    // Processing domain output
    output stream_pkg::sample_t               sample_o,
    output logic                              sample_valid_o,
    output logic                              sample_last_o,
    input  logic                              sample_ready_i,

    // Samples lost to a full FIFO, counted in the sampling domain
    output logic [stream_pkg::DROP_CNT_W-1:0] drop_count_o
);

    import stream_pkg::*;

    stream_if #(.payload_t(pair_t)) pack_if ();
    stream_if #(.payload_t(pair_t)) unpack_if ();

    pair_packer pair_packer_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sample_last_i  (sample_last_i),
        .out            (pack_if.source),
        .drop_count_o   (drop_count_o)
    );

    // Pairs cross from clk_i to out_clk_i here
    stream_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (pair_t)
    ) stream_fifo_inst (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .out_clk_i (out_clk_i),
        .wr        (pack_if.sink),
        .rd        (unpack_if.source)
    );

    pair_unpacker pair_unpacker_inst (
        .out_clk_i      (out_clk_i),
        .reset_ni       (reset_ni),
        .in             (unpack_if.sink),
        .sample_o       (sample_o),
        .sample_valid_o (sample_valid_o),
        .sample_last_o  (sample_last_o),
        .sample_ready_i (sample_ready_i)
    );

endmodule

/* dv/tb_sample_cdc_top.sv */
`timescale 1ns/1ps

module tb_sample_cdc_top;

    import stream_pkg::*;

    // The tests take a few hundred clk_i cycles, so this leaves ample margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int MAX_READY_LOW  = 3;

    typedef struct {
        sample_t value;
        logic    last;
    } expected_t;

    logic                  clk_i = 1'b0;
    logic                  out_clk_i = 1'b0;
    logic                  reset_ni = 1'b0;
    sample_t               sample_i = '0;
    logic                  sample_valid_i = 1'b0;
    logic                  sample_last_i = 1'b0;
    sample_t               sample_o;
    logic                  sample_valid_o;
    logic                  sample_last_o;
    logic                  sample_ready_i = 1'b0;
    logic [DROP_CNT_W-1:0] drop_count_o;

    expected_t   expected_q[$];
    int          error_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    int          test_err_base = 0;
    int          checked_count = 0;
    int          drop_expect = 0;
    int          low_run = 0;
    int unsigned cycle_count = 0;
    logic        random_ready = 1'b0;
    logic [31:0] lcg_state = 32'd24368;

    sample_cdc_top sample_cdc_top_inst (
        .clk_i          (clk_i),
        .out_clk_i      (out_clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sample_last_i  (sample_last_i),
        .sample_o       (sample_o),
        .sample_valid_o (sample_valid_o),
        .sample_last_o  (sample_last_o),
        .sample_ready_i (sample_ready_i),
        .drop_count_o   (drop_count_o)
    );

    always #10 clk_i = ~clk_i;
    always #7 out_clk_i = ~out_clk_i;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_sample(input sample_t got, input logic got_last,
                                input sample_t exp_value, input logic exp_last);
        if (got !== exp_value || got_last !== exp_last) begin
            $display("ERR %0t: output sample %h last %b, expected %h last %b",
                     $time, got, got_last, exp_value, exp_last);
            error_count++;
        end
    endtask

    task automatic check_count(input logic [DROP_CNT_W-1:0] got,
                               input logic [DROP_CNT_W-1:0] exp_value);
        if (got !== exp_value) begin
            $display("ERR %0t: drop_count_o is %0d, expected %0d", $time, got, exp_value);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp_value, input string what);
        if (got !== exp_value) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp_value);
            error_count++;
        end
    endtask

    // Random output ready that never stays low for more than three cycles
    always @(posedge out_clk_i) begin : drive_random_ready
        logic [31:0] rnd;
        #2;
        if (random_ready) begin
            rnd = lcg_next();
            if (low_run < MAX_READY_LOW && rnd[31:29] < 3'd3) begin
                sample_ready_i = 1'b0;
                low_run++;
            end else begin
                sample_ready_i = 1'b1;
                low_run = 0;
            end
        end
    end

    // Every output transfer is compared with the oldest sample still owed
    always @(posedge out_clk_i) begin : monitor_outputs
        expected_t head;
        if (reset_ni && sample_valid_o && sample_ready_i) begin
            if (expected_q.size() == 0) begin
                $display("Unexpected output sample %h at time %0t when none was owed",
                         sample_o, $time);
                error_count++;
            end else begin
                head = expected_q.pop_front();
                check_sample(sample_o, sample_last_o, head.value, head.last);
                checked_count++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clk_i cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Samples that the FIFO will refuse are counted instead of queued
    task automatic send_sample(input sample_t value, input logic last, input logic kept);
        @(posedge clk_i);
        #2;
        sample_i       = value;
        sample_valid_i = 1'b1;
        sample_last_i  = last;
        if (kept) begin
            expected_q.push_back('{value, last});
        end else begin
            drop_expect++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
            sample_valid_i = 1'b0;
            sample_last_i  = 1'b0;
        end
    endtask

    task automatic set_ready(input logic level);
        random_ready = 1'b0;
        @(posedge out_clk_i);
        #2;
        sample_ready_i = level;
    endtask

    // Armed before the random driver runs in the same cycle
    task automatic start_random_ready();
        @(posedge out_clk_i);
        #1;
        low_run      = 0;
        random_ready = 1'b1;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(posedge out_clk_i);
        end
        repeat (4) @(posedge out_clk_i);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_err_base) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, error_count - test_err_base);
        end
        test_err_base = error_count;
    endtask

    task automatic test_after_reset();
        repeat (12) begin
            @(posedge out_clk_i);
            #1;
            check_flag(sample_valid_o, 1'b0, "sample_valid_o after reset");
        end
        check_count(drop_count_o, '0);
        end_test("after reset");
    endtask

    task automatic test_even_frame();
        set_ready(1'b1);
        for (int i = 0; i < 10; i++) begin
            send_sample(sample_t'(16'h2000 + i), i == 9, 1'b1);
        end
        idle_cycles(1);
        wait_drain();
        check_count(drop_count_o, DROP_CNT_W'(drop_expect));
        end_test("even frame");
    endtask

    task automatic test_odd_frames();
        // The second frame starts right after a frame that ends on a first half
        for (int i = 0; i < 7; i++) begin
            send_sample(sample_t'(16'h3000 + i), i == 6, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            send_sample(sample_t'(16'h3100 + i), i == 3, 1'b1);
        end
        idle_cycles(1);
        wait_drain();
        check_count(drop_count_o, DROP_CNT_W'(drop_expect));
        end_test("odd frames");
    endtask

    task automatic test_back_pressure();
        start_random_ready();
        for (int i = 0; i < 40; i++) begin
            send_sample(sample_t'(16'h4000 + i), (i % 8) == 7, 1'b1);
            idle_cycles(3);
        end
        wait_drain();
        set_ready(1'b1);
        check_count(drop_count_o, DROP_CNT_W'(drop_expect));
        end_test("back-pressure");
    endtask

    task automatic test_overflow();
        set_ready(1'b0);
        send_sample(16'h5000, 1'b0, 1'b1);
        send_sample(16'h5001, 1'b0, 1'b1);
        idle_cycles(20);
        // Eight pairs fit in the FIFO and the last three pairs are lost
        for (int i = 0; i < 22; i++) begin
            send_sample(sample_t'(16'h5100 + i), 1'b0, i < 16);
        end
        idle_cycles(3);
        check_count(drop_count_o, DROP_CNT_W'(drop_expect));
        set_ready(1'b1);
        wait_drain();
        repeat (20) @(posedge out_clk_i);
        end_test("overflow");
    endtask

    initial begin
        repeat (5) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;
        test_after_reset();
        test_even_frame();
        test_odd_frames();
        test_back_pressure();
        test_overflow();
        $display("Tests %0d, failed %0d, errors %0d, samples checked %0d",
                 test_count, failed_tests, error_count, checked_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
source/stream_pkg.sv
source/stream_if.sv
source/gray_sync.sv
source/stream_fifo.sv
source/pair_packer.sv
source/pair_unpacker.sv
source/sample_cdc_top.sv
dv/tb_sample_cdc_top.sv
